// ==== logic/lpif_link_pkg.sv ====
package lpif_link_pkg;

  ////////////////////////////////////////////////////////////
  // Link widths

  localparam int unsigned DATA_W         = 64;
  localparam int unsigned BVALID_W       = DATA_W / 8;
  localparam int unsigned BSTART_W       = 3;
  localparam int unsigned LANE_PAYLOAD_W = 41;
  // Payload plus strobe plus marker
  localparam int unsigned LANE_W         = LANE_PAYLOAD_W + 2;

  // Strobe cadence on the lanes
  localparam int unsigned STROBE_PERIOD  = 8;
  localparam int unsigned STROBE_CNT_W   = $clog2(STROBE_PERIOD);

  ////////////////////////////////////////////////////////////
  // Vector types

  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [BVALID_W-1:0] bvalid_t;
  typedef logic [BSTART_W-1:0] bstart_t;
  typedef logic [3:0]          link_state_t;
  typedef logic [1:0]          protid_t;
  typedef logic [7:0]          delay_t;
  typedef logic [LANE_W-1:0]   lane_word_t;

  ////////////////////////////////////////////////////////////
  // Flit and lane structs

  // Valid sits on top, so it lands in the high lane
  typedef struct packed {
    logic        valid;
    link_state_t state;
    protid_t     protid;
    bstart_t     bstart;
    bvalid_t     bvalid;
    data_t       data;
  } flit_t;

  // Lane user bits, strobe above marker
  typedef struct packed {
    logic strobe;
    logic marker;
  } lane_bits_t;

  // Online delay FSM
  typedef enum logic [1:0] {
    offline,
    counting,
    online
  } sync_state_e;

endpackage

// ==== logic/lpif_auto_sync.sv ====
`timescale 1ns/1ns

module lpif_auto_sync (
  input  logic                      clk_wr,
  input  logic                      rst_n,

  input  logic                      tx_online,
  input  logic                      rx_online,
  input  lpif_link_pkg::delay_t     delay_xz_value,
  input  lpif_link_pkg::delay_t     delay_x_value,

  output logic                      tx_online_delay,
  output logic                      rx_online_delay,
  output lpif_link_pkg::lane_bits_t tx_user_bits
);

  import lpif_link_pkg::*;

  // Index 0 is TX, index 1 is RX
  logic                     [1:0] online_req;
  delay_t                   [1:0] delay_val;
  logic                     [1:0] online_delay;
  logic [STROBE_CNT_W-1:0]        word_cnt;

  assign online_req = {rx_online, tx_online};
  assign delay_val  = {delay_x_value, delay_xz_value};

  ////////////////////////////////////////////////////////////
  // Online delay counters

  for (genvar ch = 0; ch < 2; ch++) begin : g_sync
    sync_state_e state;
    delay_t      cnt;

    always_ff @(posedge clk_wr or negedge rst_n) begin
      if (!rst_n) begin
        state <= offline;
        cnt   <= '0;
      end else if (!online_req[ch]) begin
        // Drop straight back on a low request
        state <= offline;
      end else begin
        case (state)
          offline: begin
            state <= counting;
            cnt   <= delay_val[ch];
          end
          counting: begin
            if (cnt == '0) begin
              state <= online;
            end else begin
              cnt <= cnt - 1'b1;
            end
          end
          default: state <= online;
        endcase
      end
    end

    assign online_delay[ch] = (state == online);
  end

  assign tx_online_delay = online_delay[0];
  assign rx_online_delay = online_delay[1];

  ////////////////////////////////////////////////////////////
  // Strobe and marker generation

  // Word count restarts at zero on every online entry
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt <= '0;
    end else if (!tx_online_delay) begin
      word_cnt <= '0;
    end else if (word_cnt == STROBE_CNT_W'(STROBE_PERIOD - 1)) begin
      word_cnt <= '0;
    end else begin
      word_cnt <= word_cnt + 1'b1;
    end
  end

  always_comb begin
    tx_user_bits.strobe = tx_online_delay && (word_cnt == '0);
    tx_user_bits.marker = tx_online_delay;
  end

  // User bits clear one word after the online request drops
  a_user_bits_offline : assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    !tx_online |=> (tx_user_bits == '0)
  );

endmodule

// ==== logic/lpif_flit_pack.sv ====
`timescale 1ns/1ns

module lpif_flit_pack (
  input  logic                       clk_wr,
  input  logic                       rst_n,

  // Downstream user channel
  input  lpif_link_pkg::link_state_t dstrm_state,
  input  lpif_link_pkg::protid_t     dstrm_protid,
  input  lpif_link_pkg::data_t       dstrm_data,
  input  lpif_link_pkg::bstart_t     dstrm_bstart,
  input  lpif_link_pkg::bvalid_t     dstrm_bvalid,
  input  logic                       dstrm_valid,

  input  lpif_link_pkg::flit_t       rx_flit,
  input  logic                       rx_online_delay,

  output lpif_link_pkg::flit_t       tx_flit,

  // Upstream user channel
  output lpif_link_pkg::link_state_t ustrm_state,
  output lpif_link_pkg::protid_t     ustrm_protid,
  output lpif_link_pkg::data_t       ustrm_data,
  output lpif_link_pkg::bstart_t     ustrm_bstart,
  output lpif_link_pkg::bvalid_t     ustrm_bvalid,
  output logic                       ustrm_valid
);

  import lpif_link_pkg::*;

  logic                        tx_valid_q;
  logic [$bits(flit_t)-2:0]    tx_body_q;

  ////////////////////////////////////////////////////////////
  // Downstream flit register

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_valid_q <= 1'b0;
    end else begin
      tx_valid_q <= dstrm_valid;
    end
  end

  // Field order follows flit_t below valid
  always_ff @(posedge clk_wr) begin
    tx_body_q <= {dstrm_state, dstrm_protid, dstrm_bstart, dstrm_bvalid, dstrm_data};
  end

  assign tx_flit = flit_t'({tx_valid_q, tx_body_q});

  ////////////////////////////////////////////////////////////
  // Upstream register

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      ustrm_valid <= 1'b0;
    end else begin
      ustrm_valid <= rx_flit.valid && rx_online_delay;
    end
  end

  always_ff @(posedge clk_wr) begin
    ustrm_state  <= rx_flit.state;
    ustrm_protid <= rx_flit.protid;
    ustrm_data   <= rx_flit.data;
    ustrm_bstart <= rx_flit.bstart;
    ustrm_bvalid <= rx_flit.bvalid;
  end

  // Upstream valid needs RX online already when the lanes were sampled
  a_ustrm_valid_online : assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    ustrm_valid |-> $past(rx_online_delay, 2)
  );

endmodule

// ==== logic/lpif_lane_stripe.sv ====
`timescale 1ns/1ns

module lpif_lane_stripe (
  input  logic                      clk_wr,
  input  logic                      rst_n,

  input  lpif_link_pkg::flit_t      tx_flit,
  input  logic                      tx_online_delay,
  input  lpif_link_pkg::lane_bits_t tx_user_bits,
  input  logic                      rx_online_delay,

  // PHY lanes
  input  lpif_link_pkg::lane_word_t rx_phy0,
  input  lpif_link_pkg::lane_word_t rx_phy1,
  output lpif_link_pkg::lane_word_t tx_phy0,
  output lpif_link_pkg::lane_word_t tx_phy1,

  output lpif_link_pkg::flit_t      rx_flit,
  output logic                      rx_align_err
);

  import lpif_link_pkg::*;

  logic [2*LANE_PAYLOAD_W-1:0] tx_bits;
  logic                        rx_marker_ok;
  logic                        rx_pair_valid;
  logic                        rx_valid_q;
  logic [$bits(flit_t)-2:0]    rx_body_q;

  ////////////////////////////////////////////////////////////
  // Transmit striping

  assign tx_bits = tx_flit;

  // Lane 0 carries the low half, lane 1 the high half
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else if (!tx_online_delay) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= {tx_user_bits.strobe, tx_user_bits.marker,
                  tx_bits[LANE_PAYLOAD_W-1:0]};
      // Marker stays clear on lane 1
      tx_phy1 <= {tx_user_bits.strobe, 1'b0,
                  tx_bits[2*LANE_PAYLOAD_W-1:LANE_PAYLOAD_W]};
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive check and rejoin

  assign rx_marker_ok  = rx_phy0[LANE_W-2] && !rx_phy1[LANE_W-2];
  // Flit valid is the top payload bit of lane 1
  assign rx_pair_valid = rx_phy1[LANE_PAYLOAD_W-1];

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_valid_q <= 1'b0;
    end else begin
      rx_valid_q <= rx_online_delay && rx_marker_ok && rx_pair_valid;
    end
  end

  always_ff @(posedge clk_wr) begin
    rx_body_q <= {rx_phy1[LANE_PAYLOAD_W-2:0], rx_phy0[LANE_PAYLOAD_W-1:0]};
  end

  assign rx_flit = flit_t'({rx_valid_q, rx_body_q});

  // Sticky until reset
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_align_err <= 1'b0;
    end else if (rx_online_delay && rx_pair_valid && !rx_marker_ok) begin
      rx_align_err <= 1'b1;
    end
  end

  // Any lane traffic leaves with marker set on lane 0 only
  a_tx_lanes_quiet : assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    (tx_phy0 != '0 || tx_phy1 != '0) |-> (tx_phy0[LANE_W-2] && !tx_phy1[LANE_W-2])
  );

endmodule

// ==== logic/lpif_link_top.sv ====
`timescale 1ns/1ns

module lpif_link_top (
  input  logic                       clk_wr,
  input  logic                       rst_n,

  // Link control
  input  logic                       tx_online,
  input  logic                       rx_online,
  input  lpif_link_pkg::delay_t      delay_x_value,
  input  lpif_link_pkg::delay_t      delay_xz_value,

  // PHY lanes
  output lpif_link_pkg::lane_word_t  tx_phy0,
  output lpif_link_pkg::lane_word_t  tx_phy1,
  input  lpif_link_pkg::lane_word_t  rx_phy0,
  input  lpif_link_pkg::lane_word_t  rx_phy1,
  output logic                       rx_align_err,

  // Downstream channel
  input  lpif_link_pkg::link_state_t dstrm_state,
  input  lpif_link_pkg::protid_t     dstrm_protid,
  input  lpif_link_pkg::data_t       dstrm_data,
  input  lpif_link_pkg::bstart_t     dstrm_bstart,
  input  lpif_link_pkg::bvalid_t     dstrm_bvalid,
  input  logic                       dstrm_valid,

  // Upstream channel
  output lpif_link_pkg::link_state_t ustrm_state,
  output lpif_link_pkg::protid_t     ustrm_protid,
  output lpif_link_pkg::data_t       ustrm_data,
  output lpif_link_pkg::bstart_t     ustrm_bstart,
  output lpif_link_pkg::bvalid_t     ustrm_bvalid,
  output logic                       ustrm_valid
);

  import lpif_link_pkg::*;

  ////////////////////////////////////////////////////////////
  // Interconnect

  flit_t      tx_flit;
  flit_t      rx_flit;
  logic       tx_online_delay;
  logic       rx_online_delay;
  lane_bits_t tx_user_bits;

  ////////////////////////////////////////////////////////////
  // Auto sync

  lpif_auto_sync lpif_auto_sync_i (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_xz_value  (delay_xz_value),
    .delay_x_value   (delay_x_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_user_bits    (tx_user_bits)
  );

  ////////////////////////////////////////////////////////////
  // User interface

  lpif_flit_pack lpif_flit_pack_i (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_bstart    (dstrm_bstart),
    .dstrm_bvalid    (dstrm_bvalid),
    .dstrm_valid     (dstrm_valid),
    .rx_flit         (rx_flit),
    .rx_online_delay (rx_online_delay),
    .tx_flit         (tx_flit),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_bstart    (ustrm_bstart),
    .ustrm_bvalid    (ustrm_bvalid),
    .ustrm_valid     (ustrm_valid)
  );

  ////////////////////////////////////////////////////////////
  // PHY striping

  lpif_lane_stripe lpif_lane_stripe_i (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_flit         (tx_flit),
    .tx_online_delay (tx_online_delay),
    .tx_user_bits    (tx_user_bits),
    .rx_online_delay (rx_online_delay),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .rx_flit         (rx_flit),
    .rx_align_err    (rx_align_err)
  );

endmodule

// ==== verification/lpif_link_tb.sv ====
`timescale 1ns/1ns

module lpif_link_tb;

  import lpif_link_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 16;
  localparam int LOOP_FLITS   = 40;
  localparam int MAX_CYCLES   = 128;
  localparam int SWAP_FLITS   = 16;

  // Cycle budget per test, both resets included
  localparam int BUDGET      = 2 * (RESET_CYCLES + 4) + 24 + 40 + 60
                               + (12 + MAX_CYCLES + 4) + 60;
  localparam int WATCHDOG_NS = (BUDGET + 200) * CLK_PERIOD;

  logic        clk_wr;
  logic        rst_n;
  logic        tx_online;
  logic        rx_online;
  delay_t      delay_x_value;
  delay_t      delay_xz_value;
  lane_word_t  tx_phy0;
  lane_word_t  tx_phy1;
  lane_word_t  rx_phy0;
  lane_word_t  rx_phy1;
  logic        rx_align_err;
  link_state_t dstrm_state;
  protid_t     dstrm_protid;
  data_t       dstrm_data;
  bstart_t     dstrm_bstart;
  bvalid_t     dstrm_bvalid;
  logic        dstrm_valid;
  link_state_t ustrm_state;
  protid_t     ustrm_protid;
  data_t       ustrm_data;
  bstart_t     ustrm_bstart;
  bvalid_t     ustrm_bvalid;
  logic        ustrm_valid;

  logic        lanes_swapped;
  logic [31:0] rng_state;
  int          errors;
  int          checks;
  flit_t       exp_q[$];

  initial clk_wr = 1'b0;
  always #(CLK_PERIOD / 2) clk_wr = ~clk_wr;

  // External loopback, straight or crossed
  assign rx_phy0 = lanes_swapped ? tx_phy1 : tx_phy0;
  assign rx_phy1 = lanes_swapped ? tx_phy0 : tx_phy1;

  lpif_link_top dut (.*);

  ////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic flit_t random_flit(input logic valid);
    flit_t       f;
    logic [31:0] r;
    r        = next_rand();
    f.valid  = valid;
    f.state  = r[3:0];
    f.protid = r[5:4];
    f.bstart = r[8:6];
    f.bvalid = r[16:9];
    f.data   = {next_rand(), next_rand()};
    return f;
  endfunction

  task automatic drive_flit(input flit_t f);
    dstrm_valid  <= f.valid;
    dstrm_state  <= f.state;
    dstrm_protid <= f.protid;
    dstrm_bstart <= f.bstart;
    dstrm_bvalid <= f.bvalid;
    dstrm_data   <= f.data;
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL time=%0t %s: got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic compare_flit(input flit_t f);
    check_value("ustrm_valid", 64'(ustrm_valid), 64'(f.valid));
    if (f.valid) begin
      check_value("ustrm_state", 64'(ustrm_state), 64'(f.state));
      check_value("ustrm_protid", 64'(ustrm_protid), 64'(f.protid));
      check_value("ustrm_bstart", 64'(ustrm_bstart), 64'(f.bstart));
      check_value("ustrm_bvalid", 64'(ustrm_bvalid), 64'(f.bvalid));
      check_value("ustrm_data", ustrm_data, f.data);
    end
  endtask

  task automatic check_lanes_zero();
    check_value("tx_phy0", 64'(tx_phy0), 64'd0);
    check_value("tx_phy1", 64'(tx_phy1), 64'd0);
  endtask

  task automatic apply_reset();
    rst_n <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_wr);
    rst_n <= 1'b1;
    @(posedge clk_wr);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests

  task automatic offline_quiet();
    repeat (20) begin
      @(posedge clk_wr);
      drive_flit(random_flit(1'b1));
      @(negedge clk_wr);
      check_lanes_zero();
      check_value("ustrm_valid", 64'(ustrm_valid), 64'd0);
      check_value("rx_align_err", 64'(rx_align_err), 64'd0);
    end
    @(posedge clk_wr);
    drive_flit('0);
  endtask

  // Lanes leave zero on the edge after TX online rises, dly+1 edges after sampling
  task automatic online_delay_timing(input delay_t dly);
    int last;
    last = int'(dly) + 3;
    @(posedge clk_wr);
    delay_xz_value <= dly;
    tx_online      <= 1'b1;
    for (int k = 0; k < last; k++) begin
      @(negedge clk_wr);
      check_lanes_zero();
    end
    @(negedge clk_wr);
    check_value("tx_phy0 marker", 64'(tx_phy0[LANE_W-2]), 64'd1);
    check_value("tx_phy0 strobe", 64'(tx_phy0[LANE_W-1]), 64'd1);
    check_value("tx_phy1 marker", 64'(tx_phy1[LANE_W-2]), 64'd0);
    check_value("tx_phy1 strobe", 64'(tx_phy1[LANE_W-1]), 64'd1);
    @(posedge clk_wr);
    tx_online <= 1'b0;
    repeat (3) @(posedge clk_wr);
    @(negedge clk_wr);
    check_lanes_zero();
  endtask

  task automatic strobe_cadence();
    int   waited;
    logic exp_strobe;
    @(posedge clk_wr);
    delay_xz_value <= 8'd3;
    tx_online      <= 1'b1;
    waited = 0;
    @(negedge clk_wr);
    while (tx_phy0[LANE_W-2] !== 1'b1 && waited < 20) begin
      @(negedge clk_wr);
      waited++;
    end
    if (tx_phy0[LANE_W-2] !== 1'b1) begin
      errors++;
      $display("Lane 0 marker never appeared after TX was brought online");
    end else begin
      for (int w = 0; w < 3 * STROBE_PERIOD; w++) begin
        if (w > 0) begin
          @(negedge clk_wr);
        end
        exp_strobe = (w % STROBE_PERIOD == 0);
        check_value("tx_phy0 strobe", 64'(tx_phy0[LANE_W-1]), 64'(exp_strobe));
        check_value("tx_phy1 strobe", 64'(tx_phy1[LANE_W-1]), 64'(exp_strobe));
        check_value("tx_phy0 marker", 64'(tx_phy0[LANE_W-2]), 64'd1);
        check_value("tx_phy1 marker", 64'(tx_phy1[LANE_W-2]), 64'd0);
      end
    end
  endtask

  task automatic loopback_data();
    int          sent;
    logic [31:0] r;
    @(posedge clk_wr);
    delay_x_value <= 8'd4;
    rx_online     <= 1'b1;
    // RX is online delay plus two edges later, the rest is slack
    repeat (8) @(posedge clk_wr);
    sent = 0;
    exp_q.delete();
    while (sent < LOOP_FLITS && exp_q.size() < MAX_CYCLES) begin
      r = next_rand();
      exp_q.push_back(random_flit(r[1:0] != 2'b00));
      if (exp_q[exp_q.size()-1].valid) begin
        sent++;
      end
    end
    for (int j = 0; j < exp_q.size() + 4; j++) begin
      @(posedge clk_wr);
      if (j < exp_q.size()) begin
        drive_flit(exp_q[j]);
      end else begin
        drive_flit('0);
      end
      @(negedge clk_wr);
      if (j < 4) begin
        check_value("ustrm_valid", 64'(ustrm_valid), 64'd0);
      end else begin
        compare_flit(exp_q[j-4]);
      end
    end
  endtask

  task automatic lane_swap_error();
    flit_t f;
    @(posedge clk_wr);
    lanes_swapped <= 1'b1;
    for (int i = 0; i < SWAP_FLITS + 4; i++) begin
      if (i < SWAP_FLITS) begin
        f = random_flit(1'b1);
        // Lane 0 bit 40 lands where the crossed pair reads valid
        f.data[LANE_PAYLOAD_W-1] = 1'b1;
        drive_flit(f);
      end else begin
        drive_flit('0);
      end
      @(negedge clk_wr);
      check_value("ustrm_valid", 64'(ustrm_valid), 64'd0);
      @(posedge clk_wr);
    end
    lanes_swapped <= 1'b0;
    repeat (8) begin
      @(negedge clk_wr);
      check_value("rx_align_err", 64'(rx_align_err), 64'd1);
    end
    @(posedge clk_wr);
    tx_online <= 1'b0;
    rx_online <= 1'b0;
    apply_reset();
    @(negedge clk_wr);
    check_value("rx_align_err", 64'(rx_align_err), 64'd0);
    check_value("ustrm_valid", 64'(ustrm_valid), 64'd0);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog

  initial begin
    rst_n          = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    delay_x_value  = '0;
    delay_xz_value = '0;
    dstrm_state    = '0;
    dstrm_protid   = '0;
    dstrm_data     = '0;
    dstrm_bstart   = '0;
    dstrm_bvalid   = '0;
    dstrm_valid    = 1'b0;
    lanes_swapped  = 1'b0;
    rng_state      = 32'had91;
    errors         = 0;
    checks         = 0;

    apply_reset();
    offline_quiet();
    online_delay_timing(8'd5);
    online_delay_timing(8'd2);
    strobe_cadence();
    loopback_data();
    lane_swap_error();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== build.f ====
logic/lpif_link_pkg.sv
logic/lpif_auto_sync.sv
logic/lpif_flit_pack.sv
logic/lpif_lane_stripe.sv
logic/lpif_link_top.sv
verification/lpif_link_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lpif_link_tb -f build.f -o lpif_link_sim

out=$(./obj_dir/lpif_link_sim) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1
